/* verilog/icache_settings.svh */
// instruction cache size settings

`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// fetch address width
`define ICACHE_ADDR_W 32

// one instruction per fetch
`define ICACHE_WORD_W 32

// associativity
`define ICACHE_WAY_NUM 2

// line geometry, 16 bytes per line
`define ICACHE_LINE_WORDS 4
`define ICACHE_OFS_W 4

// 64 sets
`define ICACHE_IDX_W 6

// whatever is left of the address above index and offset
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_IDX_W - `ICACHE_OFS_W)

`endif

/* verilog/icache_pkg.sv */
// instruction cache types

`include "icache_settings.svh"

package icache_pkg;

  // fetch request from the front end
  typedef struct packed {
    logic                      valid;
    logic [`ICACHE_ADDR_W-1:0] addr;
  } fetch_req_t;

  // fetch response, address echoed back
  typedef struct packed {
    logic                      valid;
    logic [`ICACHE_ADDR_W-1:0] addr;
    logic [`ICACHE_WORD_W-1:0] instr;
    logic                      misaligned;
  } fetch_rsp_t;

  // invalidate one way of one set by index
  typedef struct packed {
    logic                               valid;
    logic [`ICACHE_IDX_W-1:0]           idx;
    logic [$clog2(`ICACHE_WAY_NUM)-1:0] way;
  } inv_req_t;

  // read address channel, len is beats minus one
  typedef struct packed {
    logic                      valid;
    logic [`ICACHE_ADDR_W-1:0] addr;
    logic [7:0]                len;
  } ar_chan_t;

  // read data channel
  typedef struct packed {
    logic                      valid;
    logic                      last;
    logic [`ICACHE_WORD_W-1:0] data;
  } r_chan_t;

  // one cache line, word 0 in the low bits
  typedef logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_WORD_W-1:0] line_t;

  typedef enum logic [1:0] {
    IDLE,
    MISS,
    REFILL
  } refill_state_e;

endpackage

/* verilog/icache_sdp_ram.sv */
// simple dual-port ram

module icache_sdp_ram #(
  parameter int DEPTH = 64,
  parameter int WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // registered read, write-first on a collision
  // so a replay in the cycle of a fill sees the new line
  always_ff @(posedge clk) begin
    if (we_i && (waddr_i == raddr_i)) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

/* verilog/icache_tag_array.sv */
// icache tag and valid array

`include "icache_settings.svh"

module icache_tag_array
  import icache_pkg::*;
(
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [`ICACHE_IDX_W-1:0]           raddr_i,
  input  logic [`ICACHE_TAG_W-1:0]           lookup_tag_i,
  input  logic                               lookup_en_i,
  output logic                               hit_o,
  output logic [$clog2(`ICACHE_WAY_NUM)-1:0] hit_way_o,
  output logic [$clog2(`ICACHE_WAY_NUM)-1:0] victim_way_o,
  input  logic                               fill_i,
  input  logic [`ICACHE_IDX_W-1:0]           fill_idx_i,
  input  inv_req_t                           inv_i
);

  localparam int WAY_W = $clog2(`ICACHE_WAY_NUM);
  localparam int SETS  = 1 << `ICACHE_IDX_W;

  // index that the ram output belongs to
  logic [`ICACHE_IDX_W-1:0] idx_q;

  logic [SETS-1:0][`ICACHE_WAY_NUM-1:0] valid_q;
  logic [SETS-1:0][WAY_W-1:0]           lru_q;

  logic [`ICACHE_WAY_NUM-1:0] tag_we;
  logic [`ICACHE_TAG_W-1:0]   tag_rdata [`ICACHE_WAY_NUM];
  logic [`ICACHE_WAY_NUM-1:0] match;

  // ============================================================
  // tag storage
  // ============================================================
  for (genvar w = 0; w < `ICACHE_WAY_NUM; w++) begin : g_tag_way
    assign tag_we[w] = fill_i & (victim_way_o == WAY_W'(w));

    icache_sdp_ram #(
      .DEPTH (SETS),
      .WIDTH (`ICACHE_TAG_W)
    ) u_tag_ram (
      .clk     (clk),
      .we_i    (tag_we[w]),
      .waddr_i (fill_idx_i),
      .wdata_i (lookup_tag_i),
      .raddr_i (raddr_i),
      .rdata_o (tag_rdata[w])
    );
  end

  always_ff @(posedge clk) begin
    idx_q <= raddr_i;
  end

  // ============================================================
  // hit detection
  // ============================================================
  always_comb begin
    match     = '0;
    hit_way_o = '0;
    for (int w = 0; w < `ICACHE_WAY_NUM; w++) begin
      match[w] = lookup_en_i & valid_q[idx_q][w] & (tag_rdata[w] == lookup_tag_i);
      if (match[w]) begin
        hit_way_o = WAY_W'(w);
      end
    end
  end

  assign hit_o = |match;

  // lru bit names the way to replace next
  assign victim_way_o = lru_q[idx_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      lru_q   <= '0;
    end else begin
      if (fill_i) begin
        valid_q[fill_idx_i][victim_way_o] <= 1'b1;
      end
      if (inv_i.valid) begin
        valid_q[inv_i.idx][inv_i.way] <= 1'b0;
      end
      // steer away from the way just used
      if (hit_o && (lru_q[idx_q] == hit_way_o)) begin
        lru_q[idx_q] <= ~lru_q[idx_q];
      end
    end
  end

  // a refill and an invalidate can't share stage 1
  a_fill_inv_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(fill_i && inv_i.valid));

endmodule

/* verilog/icache_refill_fsm.sv */
// icache refill state machine

`include "icache_settings.svh"

module icache_refill_fsm
  import icache_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      miss_i,
  input  logic [`ICACHE_ADDR_W-1:0] miss_addr_i,
  output ar_chan_t                  ar_o,
  input  logic                      ar_ready_i,
  input  r_chan_t                   r_i,
  output logic                      r_ready_o,
  output line_t                     line_o,
  output logic                      line_done_o
);

  localparam int CNT_W = $clog2(`ICACHE_LINE_WORDS);

  refill_state_e state_q;

  logic [`ICACHE_ADDR_W-1:0] line_addr_q;
  logic [CNT_W-1:0]          beat_cnt_q;
  logic                      beat_fire;

  // the last word bypasses the buffer
  logic [`ICACHE_LINE_WORDS-2:0][`ICACHE_WORD_W-1:0] beat_buf_q;

  assign beat_fire = (state_q == REFILL) & r_i.valid;

  // ============================================================
  // state register
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      beat_cnt_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          beat_cnt_q <= '0;
          if (miss_i) begin
            state_q <= MISS;
          end
        end
        MISS: begin
          if (ar_ready_i) begin
            state_q <= REFILL;
          end
        end
        REFILL: begin
          if (r_i.valid) begin
            beat_cnt_q <= beat_cnt_q + CNT_W'(1);
            if (r_i.last) begin
              state_q <= IDLE;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // line-aligned burst address
  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && miss_i) begin
      line_addr_q <= {miss_addr_i[`ICACHE_ADDR_W-1:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};
    end
  end

  // beats arrive in word order
  always_ff @(posedge clk) begin
    if (beat_fire && !r_i.last) begin
      beat_buf_q[beat_cnt_q] <= r_i.data;
    end
  end

  // ============================================================
  // bus and line outputs
  // ============================================================
  always_comb begin
    ar_o.valid = (state_q == MISS);
    ar_o.addr  = line_addr_q;
    ar_o.len   = 8'(`ICACHE_LINE_WORDS - 1);
  end

  assign r_ready_o   = (state_q == REFILL);
  assign line_o      = {r_i.data, beat_buf_q};
  assign line_done_o = beat_fire & r_i.last;

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_o.valid && !ar_ready_i |=> ar_o.valid && $stable(ar_o.addr) && $stable(ar_o.len));

  a_r_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
    r_i.valid |-> state_q == REFILL);

endmodule

/* verilog/icache_top.sv */
// two-way instruction cache

`include "icache_settings.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  fetch_req_t fetch_req_i,
  input  inv_req_t   inv_req_i,
  output logic       fetch_ready_o,
  output fetch_rsp_t fetch_rsp_o,
  input  logic       rsp_ready_i,
  output logic       inv_done_o,
  output ar_chan_t   ar_o,
  input  logic       ar_ready_i,
  input  r_chan_t    r_i,
  output logic       r_ready_o
);

  localparam int WAY_W = $clog2(`ICACHE_WAY_NUM);
  localparam int SETS  = 1 << `ICACHE_IDX_W;

  // low until the first edge out of reset
  logic run_q;

  // stage 1
  logic                      s1_fetch_vld_q;
  logic [`ICACHE_ADDR_W-1:0] s1_addr_q;
  logic                      s1_mis_q;
  inv_req_t                  s1_inv_q;

  logic [`ICACHE_IDX_W-1:0] s1_idx;
  logic [`ICACHE_TAG_W-1:0] s1_tag;
  logic [`ICACHE_IDX_W-1:0] rd_idx;

  logic             fsm_busy;
  logic             rsp_fire;
  logic             lookup_en;
  logic             hit;
  logic             miss;
  logic [WAY_W-1:0] hit_way;
  logic [WAY_W-1:0] victim_way;
  line_t            refill_line;
  logic             line_done;

  logic [`ICACHE_WAY_NUM-1:0] data_we;
  line_t                      data_rdata [`ICACHE_WAY_NUM];
  line_t                      hit_line;

  // ============================================================
  // stage 0 and ready
  // ============================================================
  assign fsm_busy      = ar_o.valid | r_ready_o;
  assign rsp_fire      = fetch_rsp_o.valid & rsp_ready_i;
  assign fetch_ready_o = run_q & ~fsm_busy & (~s1_fetch_vld_q | rsp_fire);

  // replay the stage-1 set while stalled
  assign rd_idx = fetch_ready_o ? fetch_req_i.addr[`ICACHE_OFS_W +: `ICACHE_IDX_W] : s1_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q          <= 1'b0;
      s1_fetch_vld_q <= 1'b0;
      s1_inv_q       <= '0;
    end else begin
      run_q <= 1'b1;
      if (fetch_ready_o) begin
        // invalidate wins, fetch keeps waiting
        s1_inv_q       <= inv_req_i;
        s1_fetch_vld_q <= fetch_req_i.valid & ~inv_req_i.valid;
      end else begin
        s1_inv_q.valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_ready_o && fetch_req_i.valid && !inv_req_i.valid) begin
      s1_addr_q <= fetch_req_i.addr;
      s1_mis_q  <= |fetch_req_i.addr[1:0];
    end
  end

  // ============================================================
  // stage 1 lookup
  // ============================================================
  assign s1_idx    = s1_addr_q[`ICACHE_OFS_W +: `ICACHE_IDX_W];
  assign s1_tag    = s1_addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign lookup_en = s1_fetch_vld_q & ~s1_mis_q;
  assign miss      = lookup_en & ~hit & ~fsm_busy;

  icache_tag_array u_tag_array (
    .clk          (clk),
    .rst_n        (rst_n),
    .raddr_i      (rd_idx),
    .lookup_tag_i (s1_tag),
    .lookup_en_i  (lookup_en),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way),
    .fill_i       (line_done),
    .fill_idx_i   (s1_idx),
    .inv_i        (s1_inv_q)
  );

  icache_refill_fsm u_refill_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .miss_i      (miss),
    .miss_addr_i (s1_addr_q),
    .ar_o        (ar_o),
    .ar_ready_i  (ar_ready_i),
    .r_i         (r_i),
    .r_ready_o   (r_ready_o),
    .line_o      (refill_line),
    .line_done_o (line_done)
  );

  // data storage, filled into the victim way
  for (genvar w = 0; w < `ICACHE_WAY_NUM; w++) begin : g_data_way
    assign data_we[w] = line_done & (victim_way == WAY_W'(w));

    icache_sdp_ram #(
      .DEPTH (SETS),
      .WIDTH ($bits(line_t))
    ) u_data_ram (
      .clk     (clk),
      .we_i    (data_we[w]),
      .waddr_i (s1_idx),
      .wdata_i (refill_line),
      .raddr_i (rd_idx),
      .rdata_o (data_rdata[w])
    );
  end

  // ============================================================
  // response
  // ============================================================
  assign hit_line = data_rdata[hit_way];

  always_comb begin
    fetch_rsp_o.valid      = s1_fetch_vld_q & (s1_mis_q | hit);
    fetch_rsp_o.addr       = s1_addr_q;
    fetch_rsp_o.misaligned = s1_mis_q;
    // misaligned fetch carries no instruction
    if (s1_mis_q) begin
      fetch_rsp_o.instr = '0;
    end else begin
      fetch_rsp_o.instr = hit_line[s1_addr_q[`ICACHE_OFS_W-1:2]];
    end
  end

  assign inv_done_o = s1_inv_q.valid;

  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_rsp_o.valid && !rsp_ready_i |=> fetch_rsp_o.valid && $stable(fetch_rsp_o));

endmodule

/* dv/icache_mem_model.sv */
// line burst memory model

`include "icache_settings.svh"

module icache_mem_model
  import icache_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  ar_chan_t ar_i,
  output logic     ar_ready_o,
  output r_chan_t  r_o,
  input  logic     r_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int BEAT_W = $clog2(`ICACHE_LINE_WORDS);

  logic [31:0]               rnd_q;
  logic [1:0]                wait_q;
  logic                      busy_q;
  logic [`ICACHE_ADDR_W-1:0] base_q;
  logic [BEAT_W-1:0]         beat_q;
  logic [`ICACHE_ADDR_W-1:0] beat_addr;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory content is a pure function of the word address
  function automatic logic [31:0] word_at(input logic [`ICACHE_ADDR_W-1:0] addr);
    return xorshift32({addr[31:2], 2'b00} ^ 32'd67);
  endfunction

  assign beat_addr  = {base_q[`ICACHE_ADDR_W-1:`ICACHE_OFS_W], beat_q, 2'b00};
  assign ar_ready_o = ~busy_q & (wait_q == 2'd0);

  always_comb begin
    r_o.valid = busy_q & (wait_q == 2'd0);
    r_o.last  = (beat_q == BEAT_W'(`ICACHE_LINE_WORDS - 1));
    r_o.data  = word_at(beat_addr);
  end

  // ============================================================
  // burst sequencing with random delays
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rnd_q  <= xorshift32(32'd67);
      wait_q <= 2'd0;
      busy_q <= 1'b0;
      base_q <= '0;
      beat_q <= '0;
    end else begin
      rnd_q <= xorshift32(rnd_q);
      if (!busy_q) begin
        if (wait_q != 2'd0) begin
          wait_q <= wait_q - 2'd1;
        end else if (ar_i.valid) begin
          busy_q <= 1'b1;
          base_q <= ar_i.addr;
          beat_q <= '0;
          wait_q <= rnd_q[1:0];
        end
      end else if (wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end else if (r_ready_i) begin
        beat_q <= beat_q + BEAT_W'(1);
        // gap before the next beat, often none
        wait_q <= rnd_q[3:2] & {2{rnd_q[4]}};
        if (r_o.last) begin
          busy_q <= 1'b0;
          // ready delay for the next burst
          wait_q <= rnd_q[6:5];
        end
      end
    end
  end

endmodule

/* dv/icache_tb.sv */
// instruction cache testbench

`include "icache_settings.svh"

module icache_tb
  import icache_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // about 40 fetches of at most 40 cycles each, plus margin
  localparam int MAX_FETCHES    = 40;
  localparam int FETCH_CYCLES   = 40;
  localparam int TIMEOUT_CYCLES = MAX_FETCHES * FETCH_CYCLES + 1400;

  logic       clk;
  logic       rst_n;
  fetch_req_t fetch_req;
  inv_req_t   inv_req;
  logic       fetch_ready;
  fetch_rsp_t fetch_rsp;
  logic       rsp_ready;
  logic       inv_done;
  ar_chan_t   ar;
  logic       ar_ready;
  r_chan_t    r;
  logic       r_ready;

  int unsigned               cycles = 0;
  int unsigned               ar_count = 0;
  logic [`ICACHE_ADDR_W-1:0] last_ar_addr = '0;
  logic [7:0]                last_ar_len = '0;
  logic                      burst_open = 1'b0;

  icache_top UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req_i   (fetch_req),
    .inv_req_i     (inv_req),
    .fetch_ready_o (fetch_ready),
    .fetch_rsp_o   (fetch_rsp),
    .rsp_ready_i   (rsp_ready),
    .inv_done_o    (inv_done),
    .ar_o          (ar),
    .ar_ready_i    (ar_ready),
    .r_i           (r),
    .r_ready_o     (r_ready)
  );

  icache_mem_model u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_i       (ar),
    .ar_ready_o (ar_ready),
    .r_o        (r),
    .r_ready_i  (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  // bus handshakes, sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      // beats are taken only between an ar handshake and the last beat
      check_eq(64'(r_ready), 64'(burst_open), "read ready outside the refill burst");
      if (ar.valid && ar_ready) begin
        ar_count     <= ar_count + 1;
        last_ar_addr <= ar.addr;
        last_ar_len  <= ar.len;
        burst_open   <= 1'b1;
      end
      if (r.valid && r_ready && r.last) begin
        burst_open <= 1'b0;
      end
    end
  end

  // ============================================================
  // helpers
  // ============================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] expected_word(input logic [`ICACHE_ADDR_W-1:0] addr);
    return xorshift32({addr[31:2], 2'b00} ^ 32'd67);
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  task automatic send_fetch(input logic [`ICACHE_ADDR_W-1:0] addr);
    @(posedge clk);
    fetch_req.valid <= 1'b1;
    fetch_req.addr  <= addr;
    @(negedge clk);
    while (!fetch_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    fetch_req <= '0;
  endtask

  task automatic send_inv(input logic [`ICACHE_IDX_W-1:0] idx, input logic way);
    @(posedge clk);
    inv_req.valid <= 1'b1;
    inv_req.idx   <= idx;
    inv_req.way   <= way;
    @(negedge clk);
    while (!fetch_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    inv_req <= '0;
  endtask

  // lat counts cycles from acceptance to a valid response
  task automatic await_rsp(output fetch_rsp_t rsp, output int lat);
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!fetch_rsp.valid);
    rsp = fetch_rsp;
  endtask

  task automatic fetch_and_check(input logic [`ICACHE_ADDR_W-1:0] addr, input int ar_delta,
                                 input bit expect_hit);
    fetch_rsp_t  rsp;
    int          lat;
    int unsigned ar_before;
    ar_before = ar_count;
    send_fetch(addr);
    await_rsp(rsp, lat);
    check_eq(64'(rsp.instr), 64'(expected_word(addr)), $sformatf("instr at %h", addr));
    check_eq(64'(rsp.addr), 64'(addr), "echoed address");
    check_eq(64'(rsp.misaligned), 64'd0, "misaligned flag");
    check_eq(64'(ar_count - ar_before), 64'(ar_delta), $sformatf("bursts for %h", addr));
    if (expect_hit) begin
      check_eq(64'(lat), 64'd1, "hit latency");
    end
  endtask

  // ============================================================
  // directed tests
  // ============================================================
  task automatic cold_miss_test();
    fetch_and_check(32'h0000_2048, 1, 1'b0);
    check_eq(64'(last_ar_addr), 64'h0000_2040, "burst address");
    check_eq(64'(last_ar_len), 64'(`ICACHE_LINE_WORDS - 1), "burst length");
  endtask

  task automatic hit_test();
    fetch_and_check(32'h0000_2040, 0, 1'b1);
    fetch_and_check(32'h0000_2044, 0, 1'b1);
    fetch_and_check(32'h0000_204c, 0, 1'b1);
  endtask

  // a, b and c all map to set 0x10
  task automatic replacement_test();
    fetch_and_check(32'h0000_0104, 1, 1'b0);
    fetch_and_check(32'h0000_0508, 1, 1'b0);
    fetch_and_check(32'h0000_0104, 0, 1'b1);
    fetch_and_check(32'h0000_090c, 1, 1'b0);
    fetch_and_check(32'h0000_0104, 0, 1'b1);
    fetch_and_check(32'h0000_0508, 1, 1'b0);
  endtask

  task automatic invalidate_test();
    send_inv(6'h10, 1'b0);
    @(negedge clk);
    check_eq(64'(inv_done), 64'd1, "invalidate done pulse");
    @(negedge clk);
    check_eq(64'(inv_done), 64'd0, "invalidate done width");
    fetch_and_check(32'h0000_0104, 1, 1'b0);
  endtask

  task automatic misaligned_test();
    fetch_rsp_t  rsp;
    int          lat;
    int unsigned ar_before;
    ar_before = ar_count;
    send_fetch(32'h0000_3002);
    await_rsp(rsp, lat);
    check_eq(64'(rsp.misaligned), 64'd1, "misaligned flag");
    check_eq(64'(rsp.addr), 64'h0000_3002, "misaligned echoed address");
    check_eq(64'(lat), 64'd1, "misaligned latency");
    check_eq(64'(ar_count - ar_before), 64'd0, "misaligned bursts");
  endtask

  task automatic backpressure_test();
    fetch_rsp_t rsp;
    int         lat;
    @(posedge clk);
    rsp_ready <= 1'b0;
    send_fetch(32'h0000_5008);
    await_rsp(rsp, lat);
    check_eq(64'(rsp.instr), 64'(expected_word(32'h0000_5008)), "held instr");
    repeat (6) begin
      @(negedge clk);
      check_eq(64'(fetch_rsp === rsp), 64'd1, "response stable under back-pressure");
      check_eq(64'(fetch_ready), 64'd0, "ready low under back-pressure");
    end
    @(posedge clk);
    rsp_ready <= 1'b1;
    fetch_and_check(32'h0000_6014, 1, 1'b0);
    fetch_and_check(32'h0000_500c, 0, 1'b1);
  endtask

  initial begin
    fetch_req = '0;
    inv_req   = '0;
    rsp_ready = 1'b1;
    rst_n     = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    cold_miss_test();
    hit_test();
    replacement_test();
    invalidate_test();
    misaligned_test();
    backpressure_test();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* list.f */
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_sdp_ram.sv
verilog/icache_tag_array.sv
verilog/icache_refill_fsm.sv
verilog/icache_top.sv
dv/icache_mem_model.sv
dv/icache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module icache_tb -Mdir "$build_dir"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/Vicache_tb" > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "RESULT: FAIL" "$log"; then
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if ! grep -q "RESULT: PASS" "$log"; then
  echo "simulation ended without a result line"
  exit 1
fi

exit 0
